// File: sim/core_stimulus.txt
# P instr1 instr2 : one instruction pair (hex)
# W lane dest data : expected writeback, S lane addr data : expected store (hex)
P 70800005 71000007
W 1 01 00000005
W 2 02 00000007
P 11844000 22082000
W 1 03 0000000c
W 2 04 00000002
P 528C2000 73081FFD
W 1 05 00000009
W 2 06 00000004
P 73800001 73800009
W 1 07 00000001
W 2 07 00000009
P 141C0000 449CC000
W 1 08 00000009
W 2 09 0000000d
P 10044000 6510A000
W 1 00 0000000c
W 2 0a 00000001
P 15802000 26004000
W 1 0b 00000005
W 2 0c fffffff9
P 76800020 8005A004
W 1 0d 00000020
S 2 00000009 00000020
P 80098000 370D8000
S 1 00000007 fffffff9
W 2 0e 00000008
P 8001C100 802CBFFF
S 1 00000100 00000008
S 2 00000004 00000009
P 67B00000 00000000
W 1 0f 00000001
P 183D0000 78801FFF
W 1 10 0000000a
W 2 11 ffffffff

// File: sources.f
hdl/core_cfg_pkg.sv
hdl/isa_pkg.sv
hdl/issue_queue.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/forwarding_unit.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/dual_issue_core.sv
sim/core_asserts.sv
sim/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core regression with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --timescale 1ns/1ps --top-module tb_core \
  -f sources.f -Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log
! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log || exit 1

// File: sim/tb_core.sv
`default_nettype none

module tb_core
  import core_cfg_pkg::*;
  import isa_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int QDEPTH = 4;

  logic     clk = 1'b0;
  logic     rst;
  logic     in_valid;
  instr_t   in_instr1;
  instr_t   in_instr2;
  logic     credit_return;
  logic     wb_valid1;
  logic     wb_valid2;
  reg_idx_t wb_dest1;
  reg_idx_t wb_dest2;
  word_t    wb_data1;
  word_t    wb_data2;
  logic     st_valid1;
  logic     st_valid2;
  word_t    st_addr1;
  word_t    st_addr2;
  word_t    st_data1;
  word_t    st_data2;

  instr_t      p1_q[$];
  instr_t      p2_q[$];
  int          w_lane_q[$];
  reg_idx_t    w_dest_q[$];
  word_t       w_data_q[$];
  int          s_lane_q[$];
  word_t       s_addr_q[$];
  word_t       s_data_q[$];
  int          n_pairs = 0;
  int          sent = 0;
  int          returned_total = 0;
  logic [31:0] lfsr = 32'h9b54_3b03;

  dual_issue_core #(.QDEPTH(QDEPTH)) i_dut (.*);

  bind dual_issue_core core_asserts #(.QDEPTH(QDEPTH)) i_asserts (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .credit_return (credit_return),
    .wb_valid1     (wb_valid1),
    .wb_valid2     (wb_valid2),
    .st_valid1     (st_valid1),
    .st_valid2     (st_valid2),
    .mem_fw2       (mem_fw2),
    .id_valid2     (id_valid2),
    .id_op2        (id_op2),
    .id_regwrite1  (id_regwrite1),
    .id_rd1        (id_rd1),
    .id_rs2        (id_rs2),
    .id_rt2        (id_rt2)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic random_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  task automatic load_stimulus();
    int          fd;
    int          lane;
    string       line;
    logic [31:0] f1;
    logic [31:0] f2;
    fd = $fopen("sim/core_stimulus.txt", "r");
    assert (fd != 0) else stop_run("Cannot open the stimulus file sim/core_stimulus.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0) begin
        case (line.getc(0))
          "P": begin
            assert ($sscanf(line, "P %h %h", f1, f2) == 2)
              else stop_run({"Malformed pair line: ", line});
            p1_q.push_back(f1);
            p2_q.push_back(f2);
          end
          "W": begin
            assert ($sscanf(line, "W %h %h %h", lane, f1, f2) == 3)
              else stop_run({"Malformed writeback line: ", line});
            w_lane_q.push_back(lane);
            w_dest_q.push_back(f1[4:0]);
            w_data_q.push_back(f2);
          end
          "S": begin
            assert ($sscanf(line, "S %h %h %h", lane, f1, f2) == 3)
              else stop_run({"Malformed store line: ", line});
            s_lane_q.push_back(lane);
            s_addr_q.push_back(f1);
            s_data_q.push_back(f2);
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
    assert (p1_q.size() > 0) else stop_run("The stimulus file holds no instruction pairs");
    n_pairs = p1_q.size();
  endtask

  task automatic check_idle_outputs(input string when);
    assert (!credit_return && !wb_valid1 && !wb_valid2 && !st_valid1 && !st_valid2)
      else stop_run($sformatf("Fail %0t: control outputs not zero %s", $time, when));
  endtask

  task automatic check_writeback(input int lane, input reg_idx_t dest, input word_t data);
    assert (w_data_q.size() != 0)
      else stop_run("Unexpected writeback after all expected writebacks were seen");
    assert ((w_lane_q[0] == lane) && (w_dest_q[0] == dest) && (w_data_q[0] == data))
      else stop_run($sformatf("Fail %0t: lane %0d wrote r%0d = %h, expected lane %0d r%0d = %h",
                              $time, lane, dest, data, w_lane_q[0], w_dest_q[0], w_data_q[0]));
    void'(w_lane_q.pop_front());
    void'(w_dest_q.pop_front());
    void'(w_data_q.pop_front());
  endtask

  task automatic check_store(input int lane, input word_t addr, input word_t data);
    assert (s_data_q.size() != 0)
      else stop_run("Unexpected store after all expected stores were seen");
    assert ((s_lane_q[0] == lane) && (s_addr_q[0] == addr) && (s_data_q[0] == data))
      else stop_run($sformatf("Fail %0t: lane %0d stored %h at %h, expected lane %0d %h at %h",
                              $time, lane, data, addr, s_lane_q[0], s_data_q[0], s_addr_q[0]));
    void'(s_lane_q.pop_front());
    void'(s_addr_q.pop_front());
    void'(s_data_q.pop_front());
  endtask

  // Outputs sampled mid-cycle with lane 1 ahead of lane 2
  always @(negedge clk) begin
    if (rst) begin
      if (credit_return) returned_total++;
      assert (returned_total <= sent) else stop_run("Credit returned with no pair outstanding");
      if (wb_valid1) check_writeback(1, wb_dest1, wb_data1);
      if (wb_valid2) check_writeback(2, wb_dest2, wb_data2);
      if (st_valid1) check_store(1, st_addr1, st_data1);
      if (st_valid2) check_store(2, st_addr2, st_data2);
    end
  end

  initial begin : watchdog
    wait (n_pairs > 0);
    repeat (n_pairs * 40 + 10) @(posedge clk);
    stop_run("Timeout: the pipeline did not deliver all expected events in time");
  end

  initial begin : main
    int   credits;
    int   idx;
    logic b0;
    logic b1;
    rst       = 1'b0;
    in_valid  = 1'b0;
    in_instr1 = '0;
    in_instr2 = '0;
    load_stimulus();
    @(posedge clk);
    @(negedge clk);
    check_idle_outputs("during reset");
    @(posedge clk);
    #1 rst = 1'b1;
    @(negedge clk);
    check_idle_outputs("after reset");
    idx = 0;
    while (idx < n_pairs) begin
      @(posedge clk);
      #1;
      // Credits seen last cycle are usable now
      credits = QDEPTH - sent + returned_total;
      random_bit(b0);
      random_bit(b1);
      if ((credits > 0) && !(b0 && b1)) begin
        in_valid  = 1'b1;
        in_instr1 = p1_q[idx];
        in_instr2 = p2_q[idx];
        sent++;
        idx++;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
    while ((w_data_q.size() != 0) || (s_data_q.size() != 0)) @(negedge clk);
    // A few more cycles to catch stray events
    repeat (4) @(negedge clk);
    if (returned_total == sent) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_run("Credits for some pairs were never returned");
    end
  end

endmodule

`default_nettype wire

// File: sim/core_asserts.sv
`default_nettype none

module core_asserts
  import core_cfg_pkg::*;
  import isa_pkg::*;
#(
  parameter int QDEPTH = 4
) (
  input logic     clk,
  input logic     rst,
  input logic     in_valid,
  input logic     credit_return,
  input logic     wb_valid1,
  input logic     wb_valid2,
  input logic     st_valid1,
  input logic     st_valid2,
  input mem_fw_t  mem_fw2,
  input logic     id_valid2,
  input opcode_t  id_op2,
  input logic     id_regwrite1,
  input reg_idx_t id_rd1,
  input reg_idx_t id_rs2,
  input reg_idx_t id_rt2
);
  timeunit 1ns;
  timeprecision 1ps;

  // Pairs sent whose credit has not come back
  int   held;
  // Pairs waiting in the queue
  int   queued;
  // A waiting pair left the queue at the last edge
  logic popped;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      held   <= 0;
      queued <= 0;
      popped <= 1'b0;
    end else begin
      held   <= held + (in_valid ? 1 : 0) - (credit_return ? 1 : 0);
      queued <= queued + (in_valid ? 1 : 0) - ((queued > 0) ? 1 : 0);
      popped <= (queued > 0);
    end
  end

  no_overflow: assert property (@(posedge clk) disable iff (!rst)
    in_valid |-> (held < QDEPTH))
    else $error("pair sent with no credit left, queue would overflow");

  credit_per_pop: assert property (@(posedge clk) disable iff (!rst)
    credit_return == popped)
    else $error("credit pulse does not match a pop of a waiting pair");

  credit_has_owner: assert property (@(posedge clk) disable iff (!rst)
    credit_return |-> (held > 0))
    else $error("credit returned with nothing outstanding");

  reset_values: assert property (@(posedge clk)
    $rose(rst) |-> (!credit_return && !wb_valid1 && !wb_valid2 && !st_valid1 && !st_valid2
                    && (mem_fw2 == MFW_NONE)))
    else $error("control outputs not cleared by reset");

  // Lane 2 may only use lane 1's result as store data
  pair_independent: assert property (@(posedge clk) disable iff (!rst)
    (id_valid2 && id_regwrite1 && (id_rd1 != '0)) |->
      ((id_rs2 != id_rd1) &&
       ((id_op2 == OP_ADDI) || (id_op2 == OP_STORE) || (id_rt2 != id_rd1))))
    else $error("lane 2 reads a register written by lane 1 of the same pair");

endmodule

`default_nettype wire

// File: hdl/dual_issue_core.sv
`default_nettype none

module dual_issue_core
  import core_cfg_pkg::*;
  import isa_pkg::*;
#(
  parameter int QDEPTH = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  instr_t   in_instr1,
  input  instr_t   in_instr2,
  output logic     credit_return,
  output logic     wb_valid1,
  output logic     wb_valid2,
  output reg_idx_t wb_dest1,
  output reg_idx_t wb_dest2,
  output word_t    wb_data1,
  output word_t    wb_data2,
  output logic     st_valid1,
  output logic     st_valid2,
  output word_t    st_addr1,
  output word_t    st_addr2,
  output word_t    st_data1,
  output word_t    st_data2
);

  logic     pop_valid;
  instr_t   pop_instr1, pop_instr2;

  // ID/EX
  logic     id_valid1, id_valid2;
  opcode_t  id_op1, id_op2;
  reg_idx_t id_rd1, id_rd2, id_rs1, id_rs2, id_rt1, id_rt2;
  word_t    id_imm1, id_imm2, id_rs_val1, id_rs_val2, id_rt_val1, id_rt_val2;
  logic     id_regwrite1, id_regwrite2, id_store2;

  fwd_sel_t fwd_a1, fwd_b1, fwd_a2, fwd_b2;
  mem_fw_t  mem_fw1, mem_fw2;

  // EX/MEM
  logic     ex_valid1, ex_valid2;
  opcode_t  ex_op1, ex_op2;
  reg_idx_t ex_dest1, ex_dest2;
  logic     ex_regwrite1, ex_regwrite2;
  word_t    ex_result1, ex_result2, ex_store_data1, ex_store_data2;

  issue_queue #(.QDEPTH(QDEPTH)) u_queue (.*);

  // Register file writes come from MEM/WB
  decode_stage u_decode (
    .*,
    .we1    (wb_valid1),
    .we2    (wb_valid2),
    .waddr1 (wb_dest1),
    .waddr2 (wb_dest2),
    .wdata1 (wb_data1),
    .wdata2 (wb_data2)
  );

  forwarding_unit u_fwd (
    .*,
    .rs1           (id_rs1),
    .rt1           (id_rt1),
    .rs2           (id_rs2),
    .rt2           (id_rt2),
    .rd1           (id_rd1),
    .regwrite1     (id_regwrite1),
    .store2_ex     (id_store2),
    .dest1_ex      (ex_dest1),
    .dest2_ex      (ex_dest2),
    .regwrite1_ex  (ex_regwrite1),
    .regwrite2_ex  (ex_regwrite2),
    .dest1_mem     (wb_dest1),
    .dest2_mem     (wb_dest2),
    .regwrite1_mem (wb_valid1),
    .regwrite2_mem (wb_valid2)
  );

  execute_stage u_execute (
    .*,
    .mem_result1 (wb_data1),
    .mem_result2 (wb_data2),
    .mem_dest1   (wb_dest1)
  );

  mem_stage u_mem (.*);

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`default_nettype none

module mem_stage
  import core_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     ex_valid1,
  input  logic     ex_valid2,
  input  opcode_t  ex_op1,
  input  opcode_t  ex_op2,
  input  reg_idx_t ex_dest1,
  input  reg_idx_t ex_dest2,
  input  logic     ex_regwrite1,
  input  logic     ex_regwrite2,
  input  word_t    ex_result1,
  input  word_t    ex_result2,
  input  word_t    ex_store_data1,
  input  word_t    ex_store_data2,
  input  mem_fw_t  mem_fw1,
  input  mem_fw_t  mem_fw2,
  output logic     st_valid1,
  output logic     st_valid2,
  output word_t    st_addr1,
  output word_t    st_addr2,
  output word_t    st_data1,
  output word_t    st_data2,
  output logic     wb_valid1,
  output logic     wb_valid2,
  output reg_idx_t wb_dest1,
  output reg_idx_t wb_dest2,
  output word_t    wb_data1,
  output word_t    wb_data2
);

  assign st_valid1 = ex_valid1 && (ex_op1 == OP_STORE);
  assign st_valid2 = ex_valid2 && (ex_op2 == OP_STORE);
  assign st_addr1  = ex_result1;
  assign st_addr2  = ex_result2;

  // Partner lane's fresh result replaces stale store data
  assign st_data1 = (mem_fw1 == MFW_LANE2) ? ex_result2 : ex_store_data1;
  assign st_data2 = (mem_fw2 == MFW_LANE1) ? ex_result1 : ex_store_data2;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wb_valid1 <= 1'b0;
      wb_valid2 <= 1'b0;
    end else begin
      wb_valid1 <= ex_valid1 && ex_regwrite1;
      wb_valid2 <= ex_valid2 && ex_regwrite2;
    end
  end

  always_ff @(posedge clk) begin
    wb_dest1 <= ex_dest1;
    wb_dest2 <= ex_dest2;
    wb_data1 <= ex_result1;
    wb_data2 <= ex_result2;
  end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`default_nettype none

module execute_stage
  import core_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     id_valid1,
  input  logic     id_valid2,
  input  opcode_t  id_op1,
  input  opcode_t  id_op2,
  input  reg_idx_t id_rd1,
  input  reg_idx_t id_rd2,
  input  word_t    id_imm1,
  input  word_t    id_imm2,
  input  word_t    id_rs_val1,
  input  word_t    id_rs_val2,
  input  word_t    id_rt_val1,
  input  word_t    id_rt_val2,
  input  logic     id_regwrite1,
  input  logic     id_regwrite2,
  input  fwd_sel_t fwd_a1,
  input  fwd_sel_t fwd_b1,
  input  fwd_sel_t fwd_a2,
  input  fwd_sel_t fwd_b2,
  input  word_t    mem_result1,
  input  word_t    mem_result2,
  input  reg_idx_t mem_dest1,
  output logic     ex_valid1,
  output logic     ex_valid2,
  output opcode_t  ex_op1,
  output opcode_t  ex_op2,
  output reg_idx_t ex_dest1,
  output reg_idx_t ex_dest2,
  output logic     ex_regwrite1,
  output logic     ex_regwrite2,
  output word_t    ex_result1,
  output word_t    ex_result2,
  output word_t    ex_store_data1,
  output word_t    ex_store_data2
);

  word_t a1, b1, a2, b2;
  word_t alu1, alu2;

  function automatic word_t bypass(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_EX1:  return ex_result1;
      FWD_EX2:  return ex_result2;
      // Register 0 never supplies a value
      FWD_MEM1: return (mem_dest1 == '0) ? '0 : mem_result1;
      FWD_MEM2: return mem_result2;
      default:  return rf_val;
    endcase
  endfunction

  function automatic word_t alu(opcode_t op, word_t a, word_t b, word_t imm);
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_SLT:   return word_t'($signed(a) < $signed(b));
      // Store result is its address
      OP_ADDI,
      OP_STORE: return a + imm;
      default:  return '0;
    endcase
  endfunction

  always_comb begin
    a1   = bypass(fwd_a1, id_rs_val1);
    b1   = bypass(fwd_b1, id_rt_val1);
    a2   = bypass(fwd_a2, id_rs_val2);
    b2   = bypass(fwd_b2, id_rt_val2);
    alu1 = alu(id_op1, a1, b1, id_imm1);
    alu2 = alu(id_op2, a2, b2, id_imm2);
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ex_valid1    <= 1'b0;
      ex_valid2    <= 1'b0;
      ex_regwrite1 <= 1'b0;
      ex_regwrite2 <= 1'b0;
    end else begin
      ex_valid1    <= id_valid1;
      ex_valid2    <= id_valid2;
      ex_regwrite1 <= id_regwrite1;
      ex_regwrite2 <= id_regwrite2;
    end
  end

  always_ff @(posedge clk) begin
    ex_op1         <= id_op1;
    ex_op2         <= id_op2;
    ex_dest1       <= id_rd1;
    ex_dest2       <= id_rd2;
    ex_result1     <= alu1;
    ex_result2     <= alu2;
    ex_store_data1 <= b1;
    ex_store_data2 <= b2;
  end

endmodule

`default_nettype wire

// File: hdl/forwarding_unit.sv
`default_nettype none

module forwarding_unit
  import core_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rt1,
  input  reg_idx_t rs2,
  input  reg_idx_t rt2,
  input  reg_idx_t rd1,
  input  logic     regwrite1,
  input  logic     store2_ex,
  input  reg_idx_t dest1_ex,
  input  reg_idx_t dest2_ex,
  input  logic     regwrite1_ex,
  input  logic     regwrite2_ex,
  input  reg_idx_t dest1_mem,
  input  reg_idx_t dest2_mem,
  input  logic     regwrite1_mem,
  input  logic     regwrite2_mem,
  output fwd_sel_t fwd_a1,
  output fwd_sel_t fwd_b1,
  output fwd_sel_t fwd_a2,
  output fwd_sel_t fwd_b2,
  output mem_fw_t  mem_fw1,
  output mem_fw_t  mem_fw2
);

  logic d1ex_live, d2ex_live, d1mem_live, d2mem_live;

  // Writes to register 0 are never forwarded
  assign d1ex_live  = regwrite1_ex && (dest1_ex != '0);
  assign d2ex_live  = regwrite2_ex && (dest2_ex != '0);
  assign d1mem_live = regwrite1_mem && (dest1_mem != '0);
  assign d2mem_live = regwrite2_mem && (dest2_mem != '0);

  // Ordered youngest first, lane 2 ahead of lane 1
  function automatic logic [3:0] hits(reg_idx_t src);
    return {d2ex_live && (dest2_ex == src),
            d1ex_live && (dest1_ex == src),
            d2mem_live && (dest2_mem == src),
            d1mem_live && (dest1_mem == src)};
  endfunction

  function automatic fwd_sel_t encode(logic [3:0] hit);
    casez (hit)
      4'b1???: return FWD_EX2;
      4'b01??: return FWD_EX1;
      4'b001?: return FWD_MEM2;
      4'b0001: return FWD_MEM1;
      default: return FWD_RF;
    endcase
  endfunction

  always_comb begin
    fwd_a1 = FWD_RF;
    fwd_b1 = FWD_RF;
    fwd_a2 = FWD_RF;
    fwd_b2 = FWD_RF;
    // Register file only while in reset
    if (rst) begin
      fwd_a1 = encode(hits(rs1));
      fwd_b1 = encode(hits(rt1));
      fwd_a2 = encode(hits(rs2));
      fwd_b2 = encode(hits(rt2));
    end
  end

  // Lane 1 has no older partner in its pair
  assign mem_fw1 = MFW_NONE;

  // Store data from the same pair's lane 1, lined up with MEM
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mem_fw2 <= MFW_NONE;
    end else if (store2_ex && regwrite1 && (rd1 != '0) && (rt2 == rd1)) begin
      mem_fw2 <= MFW_LANE1;
    end else begin
      mem_fw2 <= MFW_NONE;
    end
  end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`default_nettype none

module decode_stage
  import core_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     pop_valid,
  input  instr_t   pop_instr1,
  input  instr_t   pop_instr2,
  input  logic     we1,
  input  logic     we2,
  input  reg_idx_t waddr1,
  input  reg_idx_t waddr2,
  input  word_t    wdata1,
  input  word_t    wdata2,
  output logic     id_valid1,
  output logic     id_valid2,
  output opcode_t  id_op1,
  output opcode_t  id_op2,
  output reg_idx_t id_rd1,
  output reg_idx_t id_rd2,
  output reg_idx_t id_rs1,
  output reg_idx_t id_rs2,
  output reg_idx_t id_rt1,
  output reg_idx_t id_rt2,
  output word_t    id_imm1,
  output word_t    id_imm2,
  output word_t    id_rs_val1,
  output word_t    id_rs_val2,
  output word_t    id_rt_val1,
  output word_t    id_rt_val2,
  output logic     id_regwrite1,
  output logic     id_regwrite2,
  output logic     id_store2
);

  opcode_t op1;
  opcode_t op2;
  word_t   rs_val1, rt_val1, rs_val2, rt_val2;

  assign op1 = instr_op(pop_instr1);
  assign op2 = instr_op(pop_instr2);

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (instr_rs(pop_instr1)),
    .raddr1 (instr_rt(pop_instr1)),
    .raddr2 (instr_rs(pop_instr2)),
    .raddr3 (instr_rt(pop_instr2)),
    .rdata0 (rs_val1),
    .rdata1 (rt_val1),
    .rdata2 (rs_val2),
    .rdata3 (rt_val2),
    .we1    (we1),
    .we2    (we2),
    .waddr1 (waddr1),
    .waddr2 (waddr2),
    .wdata1 (wdata1),
    .wdata2 (wdata2)
  );

  // Empty queue or NOP becomes a bubble
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      id_valid1    <= 1'b0;
      id_valid2    <= 1'b0;
      id_regwrite1 <= 1'b0;
      id_regwrite2 <= 1'b0;
      id_store2    <= 1'b0;
    end else begin
      id_valid1    <= pop_valid && (op1 != OP_NOP);
      id_valid2    <= pop_valid && (op2 != OP_NOP);
      id_regwrite1 <= pop_valid && writes_reg(op1);
      id_regwrite2 <= pop_valid && writes_reg(op2);
      id_store2    <= pop_valid && (op2 == OP_STORE);
    end
  end

  always_ff @(posedge clk) begin
    id_op1     <= op1;
    id_op2     <= op2;
    id_rd1     <= instr_rd(pop_instr1);
    id_rd2     <= instr_rd(pop_instr2);
    id_rs1     <= instr_rs(pop_instr1);
    id_rs2     <= instr_rs(pop_instr2);
    id_rt1     <= instr_rt(pop_instr1);
    id_rt2     <= instr_rt(pop_instr2);
    id_imm1    <= instr_imm(pop_instr1);
    id_imm2    <= instr_imm(pop_instr2);
    id_rs_val1 <= rs_val1;
    id_rs_val2 <= rs_val2;
    id_rt_val1 <= rt_val1;
    id_rt_val2 <= rt_val2;
  end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file
  import core_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t raddr0,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  reg_idx_t raddr3,
  output word_t    rdata0,
  output word_t    rdata1,
  output word_t    rdata2,
  output word_t    rdata3,
  input  logic     we1,
  input  logic     we2,
  input  reg_idx_t waddr1,
  input  reg_idx_t waddr2,
  input  word_t    wdata1,
  input  word_t    wdata2
);

  word_t regs [1:31];

  // Same-cycle write shows up on the read, lane 2 first
  function automatic word_t read_port(reg_idx_t a);
    if (a == '0) return '0;
    if (we2 && (waddr2 == a)) return wdata2;
    if (we1 && (waddr1 == a)) return wdata1;
    return regs[a];
  endfunction

  always_comb begin
    rdata0 = read_port(raddr0);
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
    rdata3 = read_port(raddr3);
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else begin
      if (we1 && (waddr1 != '0)) regs[waddr1] <= wdata1;
      // Later write wins on a shared index
      if (we2 && (waddr2 != '0)) regs[waddr2] <= wdata2;
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_queue.sv
`default_nettype none

module issue_queue
  import isa_pkg::*;
#(
  parameter int QDEPTH = 4
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  input  instr_t in_instr1,
  input  instr_t in_instr2,
  output logic   pop_valid,
  output instr_t pop_instr1,
  output instr_t pop_instr2,
  output logic   credit_return
);

  localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

  instr_t           slot1 [QDEPTH];
  instr_t           slot2 [QDEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(QDEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Downstream never stalls
  assign do_pop = (count != '0);

  // One credit back per popped pair
  assign credit_return = pop_valid;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
    end else begin
      if (in_valid) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({in_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      pop_valid <= do_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      slot1[wr_ptr] <= in_instr1;
      slot2[wr_ptr] <= in_instr2;
    end
    if (do_pop) begin
      pop_instr1 <= slot1[rd_ptr];
      pop_instr2 <= slot2[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;
  import core_cfg_pkg::*;

  // opcode 31:28, rd 27:23, rs 22:18, rt 17:13, imm 12:0
  typedef logic [31:0] instr_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0, OP_ADD  = 4'h1, OP_SUB   = 4'h2, OP_AND = 4'h3, OP_OR = 4'h4,
    OP_XOR  = 4'h5, OP_SLT  = 4'h6, OP_ADDI  = 4'h7, OP_STORE = 4'h8
  } opcode_t;

  function automatic opcode_t instr_op(instr_t i);
    return opcode_t'(i[31:28]);
  endfunction

  function automatic reg_idx_t instr_rd(instr_t i);
    return i[27:23];
  endfunction

  function automatic reg_idx_t instr_rs(instr_t i);
    return i[22:18];
  endfunction

  function automatic reg_idx_t instr_rt(instr_t i);
    return i[17:13];
  endfunction

  // Sign-extended immediate
  function automatic word_t instr_imm(instr_t i);
    return {{(WORD_W-13){i[12]}}, i[12:0]};
  endfunction

  function automatic logic writes_reg(opcode_t op);
    return !(op inside {OP_NOP, OP_STORE});
  endfunction

endpackage

`default_nettype wire

// File: hdl/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // One-hot operand source for the EX muxes
  typedef logic [4:0] fwd_sel_t;

  localparam fwd_sel_t FWD_RF   = 5'b00001;
  localparam fwd_sel_t FWD_EX1  = 5'b00010;
  localparam fwd_sel_t FWD_MEM1 = 5'b00100;
  localparam fwd_sel_t FWD_EX2  = 5'b01000;
  localparam fwd_sel_t FWD_MEM2 = 5'b10000;

  // Store-data source while the store sits in MEM
  typedef logic [1:0] mem_fw_t;

  localparam mem_fw_t MFW_NONE  = 2'b00;
  localparam mem_fw_t MFW_LANE1 = 2'b01;
  localparam mem_fw_t MFW_LANE2 = 2'b10;

endpackage

`default_nettype wire
